/* Bender.yml */
package:
  name: chitchat

sources:
  - hdl/chitchat_pkg.sv
  - hdl/chitchat_crc16.sv
  - hdl/chitchat_tx.sv
  - hdl/chitchat_rx.sv
  - hdl/chitchat_txrx_wrap.sv
  - target: test
    files:
      - dv/chitchat_checker.sv
      - dv/chitchat_tb.sv

/* dv/chitchat_checker.sv */
// Link checker that decodes both wire streams, predicts receive results and compares them
`default_nettype none

module chitchat_checker #(
   parameter logic [31:0] rev_id        = 32'h0,
   parameter logic [2:0]  gateware_type = 3'd0
) (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   transmit_en,
   input  logic [15:0]            gtx_tx_d,
   input  logic                   gtx_tx_k,
   input  logic [15:0]            gtx_rx_d,
   input  logic                   gtx_rx_k,
   input  logic                   rx_valid,
   input  chitchat_pkg::payload_t rx_payload,
   input  chitchat_pkg::rx_info_t rx_info,
   input  logic [15:0]            rx_frame_cnt,
   input  logic                   ccrx_frame_drop,
   input  chitchat_pkg::fault_t   ccrx_fault,
   input  logic [15:0]            ccrx_fault_cnt,
   input  logic                   ccrx_los,
   input  logic [15:0]            txrx_latency,
   input  logic [79:0]            test_name,
   input  chitchat_pkg::payload_t exp_payload,
   input  logic [2:0]             exp_location,
   output int                     errors
);
   import chitchat_pkg::*;

   // Receive model
   logic        r_open;
   int          r_idx;
   logic [15:0] r_crc;
   logic [15:0] r_words [1:9];
   logic [79:0] r_name;
   payload_t    r_pay;
   logic [2:0]  r_loc;
   int          los_run;
   logic [15:0] m_last_good;
   // Outputs expected after the current edge
   logic        p_valid;
   logic        p_drop;
   logic        p_k_err;
   logic        p_los;
   logic [79:0] p_name;
   payload_t    p_pay;
   logic [2:0]  p_loc;
   logic [15:0] p_cnt;
   logic [15:0] p_lb;
   logic [15:0] m_fault_cnt;
   // Latency waits for word 8 of the frame in transmission
   logic        lat_pend;
   logic [15:0] lat_lb;
   logic [79:0] lat_name;
   logic [15:0] lat_exp;
   // Transmit decoder
   int          t_idx;
   logic [15:0] t_crc;
   logic [15:0] t_cnt;
   logic        en_d1;
   logic        en_d2;
   logic        comma;

   // CCITT polynomial applied MSB first
   function automatic logic [15:0] crc_ccitt(input logic [15:0] c, input logic [15:0] w);
      logic [15:0] r;
      r = c;
      for (int b = 15; b >= 0; b--) begin
         r = (r[15] ^ w[b]) ? ({r[14:0], 1'b0} ^ crc_poly) : {r[14:0], 1'b0};
      end
      return r;
   endfunction

   task automatic check_value(input logic [79:0] name, input string what,
                              input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act) begin
         errors++;
         $display("error %0s %0s: expected %0h actual %0h", name, what, exp, act);
      end
   endtask

   task automatic report_text(input string msg);
      errors++;
      $display("failure in %0s: %0s", test_name, msg);
   endtask

   always @(posedge clk) begin
      if (rst) begin
         errors      = 0;
         r_open      = 1'b0;
         r_idx       = 0;
         r_crc       = crc_init;
         los_run     = 0;
         m_last_good = '0;
         p_valid     = 1'b0;
         p_drop      = 1'b0;
         p_k_err     = 1'b0;
         p_los       = 1'b0;
         p_name      = test_name;
         m_fault_cnt = '0;
         lat_pend    = 1'b0;
         t_idx       = w_crc;
         t_crc       = crc_init;
         t_cnt       = '0;
         en_d1       = 1'b0;
         en_d2       = 1'b0;
      end else begin
         // --------------------
         // Compare with last prediction
         // --------------------
         check_value(p_name, "rx_valid", p_valid, rx_valid);
         check_value(p_name, "frame_drop", p_drop, ccrx_frame_drop);
         check_value(test_name, "los", p_los, ccrx_los);
         check_value(test_name, "fault_cnt", m_fault_cnt, ccrx_fault_cnt);
         if (p_valid && rx_valid) begin
            check_value(p_name, "payload", p_pay, rx_payload);
            check_value(p_name, "protocol_ver", protocol_ver, rx_info.protocol_ver);
            check_value(p_name, "gateware_type", gateware_type, rx_info.gateware_type);
            check_value(p_name, "location", p_loc, rx_info.location);
            check_value(p_name, "rev_id", rev_id, rx_info.rev_id);
            check_value(p_name, "frame_cnt", p_cnt, rx_frame_cnt);
            lat_pend = 1'b1;
            lat_lb   = p_lb;
            lat_name = p_name;
         end
         // Good frame counter that the far end echoes in word 9
         if (p_valid) begin
            m_last_good = p_cnt;
         end
         if (p_drop && ccrx_frame_drop) begin
            check_value(p_name, "fault k", p_k_err, ccrx_fault.k_err);
            if (!p_k_err) begin
               check_value(p_name, "fault crc", 1'b1, ccrx_fault.crc_err);
            end
         end
         if (p_drop && m_fault_cnt != 16'hffff) begin
            m_fault_cnt++;
         end

         // --------------------
         // Receive prediction
         // --------------------
         p_valid = 1'b0;
         p_drop  = 1'b0;
         p_k_err = 1'b0;
         comma   = gtx_rx_k && (gtx_rx_d == comma_code);
         if (comma) begin
            los_run = 0;
         end else if (los_run < los_limit) begin
            los_run++;
         end
         p_los = (los_run >= los_limit);
         if (r_open && gtx_rx_k) begin
            // Any k word inside a frame ends it
            p_drop  = 1'b1;
            p_k_err = 1'b1;
            p_name  = r_name;
            r_open  = 1'b0;
         end else if (r_open && r_idx < w_crc) begin
            r_words[r_idx] = gtx_rx_d;
            r_crc          = crc_ccitt(r_crc, gtx_rx_d);
            r_idx++;
         end else if (r_open) begin
            p_name = r_name;
            if (r_crc == gtx_rx_d) begin
               p_valid = 1'b1;
               p_pay   = r_pay;
               p_loc   = r_loc;
               p_cnt   = r_words[w_frame_cnt];
               p_lb    = r_words[w_lback_cnt];
            end else begin
               p_drop = 1'b1;
            end
            r_open = 1'b0;
         end
         if (comma) begin
            r_open = 1'b1;
            r_idx  = w_header;
            r_crc  = crc_init;
            r_name = test_name;
            r_pay  = exp_payload;
            r_loc  = exp_location;
         end

         // --------------------
         // Transmit stream
         // --------------------
         if (gtx_tx_k) begin
            if (gtx_tx_d != comma_code) begin
               check_value(test_name, "k word", comma_code, gtx_tx_d);
            end
            if (t_idx != w_comma && t_idx != w_crc) begin
               report_text("a comma cut a transmitted frame short");
            end
            t_idx = w_comma;
         end else if (t_idx == w_crc) begin
            report_text("data word sent outside a frame");
         end else begin
            t_idx++;
            // Frame start two edges back needs transmit_en
            if (t_idx == w_header) begin
               if (!en_d2) begin
                  report_text("frame sent while transmit_en was low");
               end
               t_crc = crc_init;
               t_cnt++;
            end
            if (t_idx == w_crc) begin
               check_value(test_name, "tx crc", t_crc, gtx_tx_d);
            end else begin
               t_crc = crc_ccitt(t_crc, gtx_tx_d);
            end
            if (t_idx == w_frame_cnt) begin
               check_value(test_name, "tx frame_cnt", t_cnt, gtx_tx_d);
            end
            if (t_idx == w_lback_cnt) begin
               check_value(test_name, "tx lback_cnt", m_last_good, gtx_tx_d);
            end
            if (t_idx == w_frame_cnt && lat_pend) begin
               lat_exp = gtx_tx_d - lat_lb;
               check_value(lat_name, "txrx_latency", lat_exp, txrx_latency);
               lat_pend = 1'b0;
            end
         end
         en_d2 = en_d1;
         en_d1 = transmit_en;
      end
   end

endmodule

`default_nettype wire

/* dv/chitchat_tb.sv */
// Testbench top with clock, reset, stimulus table, corrupting loopback and timeout
`default_nettype none

module chitchat_tb;
   import chitchat_pkg::*;

   localparam logic [31:0] tb_rev_id      = 32'h5a17_0c03;
   localparam logic [2:0]  tb_gw_type     = 3'd5;
   localparam int          n_tests        = 14;
   localparam int          timeout_cycles = (n_tests + 4) * frame_words * 2;
   localparam logic [3:0]  no_corrupt     = 4'hf;

   typedef struct packed {
      logic [79:0] name;
      logic [31:0] data0;
      logic [31:0] data1;
      logic [2:0]  location;
      logic [3:0]  corrupt;    // word index to hit, no_corrupt for a clean frame
      logic        dead;
   } stim_t;

   // --------------------
   // Stimulus table
   // --------------------
   stim_t tests [n_tests] = '{
      '{"basic_0",  32'h0123_4567, 32'h89ab_cdef, 3'd1, no_corrupt, 1'b0},
      '{"basic_1",  32'hdead_beef, 32'h0000_0001, 3'd2, no_corrupt, 1'b0},
      '{"crc_hdr",  32'h1111_2222, 32'h3333_4444, 3'd3, 4'd1,       1'b0},
      '{"good_2",   32'hffff_0000, 32'h0000_ffff, 3'd4, no_corrupt, 1'b0},
      '{"crc_cnt",  32'h5555_aaaa, 32'haaaa_5555, 3'd5, 4'd8,       1'b0},
      '{"crc_word", 32'h0f0f_f0f0, 32'h7777_8888, 3'd6, 4'd10,      1'b0},
      '{"crc_data", 32'h1234_8765, 32'h2468_ace0, 3'd7, 4'd5,       1'b0},
      '{"dead_0",   32'h0,         32'h0,         3'd0, no_corrupt, 1'b1},
      '{"dead_1",   32'h0,         32'h0,         3'd0, no_corrupt, 1'b1},
      '{"dead_2",   32'h0,         32'h0,         3'd0, no_corrupt, 1'b1},
      '{"dead_3",   32'h0,         32'h0,         3'd0, no_corrupt, 1'b1},
      '{"relink",   32'hcafe_f00d, 32'hbead_0042, 3'd2, no_corrupt, 1'b0},
      '{"relink_2", 32'h0bad_c0de, 32'h600d_f00d, 3'd6, no_corrupt, 1'b0},
      '{"final",    32'h8000_0001, 32'h7fff_fffe, 3'd3, no_corrupt, 1'b0}
   };

   logic        gtx_tx_clk;
   logic        rst;
   logic        transmit_en;
   logic        tx_valid;
   logic [2:0]  location;
   payload_t    tx_payload;
   logic        rx_valid;
   payload_t    rx_payload;
   rx_info_t    rx_info;
   logic [15:0] rx_frame_cnt;
   logic        ccrx_frame_drop;
   fault_t      ccrx_fault;
   logic [15:0] ccrx_fault_cnt;
   logic        ccrx_los;
   logic [15:0] txrx_latency;
   logic [15:0] gtx_tx_d;
   logic        gtx_tx_k;
   logic [15:0] gtx_rx_d;
   logic        gtx_rx_k;

   logic        link_dead;
   logic [15:0] flip_mask;
   logic [79:0] wire_name;
   payload_t    wire_payload;
   logic [2:0]  wire_loc;
   logic [31:0] lfsr_state;
   int          checker_errors;
   int          cycle_cnt;

   // Loopback with a single bit flip or a dead line
   assign gtx_rx_d = link_dead ? 16'h0000 : (gtx_tx_d ^ flip_mask);
   assign gtx_rx_k = link_dead ? 1'b0 : gtx_tx_k;

   chitchat_txrx_wrap #(
      .rev_id        (tb_rev_id),
      .gateware_type (tb_gw_type)
   ) UUT (
      .gtx_tx_clk      (gtx_tx_clk),
      .rst             (rst),
      .transmit_en     (transmit_en),
      .tx_valid        (tx_valid),
      .location        (location),
      .tx_payload      (tx_payload),
      .rx_valid        (rx_valid),
      .rx_payload      (rx_payload),
      .rx_info         (rx_info),
      .rx_frame_cnt    (rx_frame_cnt),
      .ccrx_frame_drop (ccrx_frame_drop),
      .ccrx_fault      (ccrx_fault),
      .ccrx_fault_cnt  (ccrx_fault_cnt),
      .ccrx_los        (ccrx_los),
      .txrx_latency    (txrx_latency),
      .gtx_tx_d        (gtx_tx_d),
      .gtx_tx_k        (gtx_tx_k),
      .gtx_rx_d        (gtx_rx_d),
      .gtx_rx_k        (gtx_rx_k)
   );

   chitchat_checker #(
      .rev_id        (tb_rev_id),
      .gateware_type (tb_gw_type)
   ) i_checker (
      .clk             (gtx_tx_clk),
      .rst             (rst),
      .transmit_en     (transmit_en),
      .gtx_tx_d        (gtx_tx_d),
      .gtx_tx_k        (gtx_tx_k),
      .gtx_rx_d        (gtx_rx_d),
      .gtx_rx_k        (gtx_rx_k),
      .rx_valid        (rx_valid),
      .rx_payload      (rx_payload),
      .rx_info         (rx_info),
      .rx_frame_cnt    (rx_frame_cnt),
      .ccrx_frame_drop (ccrx_frame_drop),
      .ccrx_fault      (ccrx_fault),
      .ccrx_fault_cnt  (ccrx_fault_cnt),
      .ccrx_los        (ccrx_los),
      .txrx_latency    (txrx_latency),
      .test_name       (wire_name),
      .exp_payload     (wire_payload),
      .exp_location    (wire_loc),
      .errors          (checker_errors)
   );

   initial begin
      gtx_tx_clk = 1'b0;
      forever #4 gtx_tx_clk = ~gtx_tx_clk;
   end

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic pick_flip_mask(output logic [15:0] mask);
      logic [3:0] pos;
      pos = '0;
      for (int b = 0; b < 4; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         pos        = {pos[2:0], lfsr_state[0]};
      end
      mask = 16'h0001 << pos;
   endtask

   // One frame on the wire, word k set up on the k-th falling edge
   task automatic drive_frame(input int i);
      logic [15:0] mask;
      mask = '0;
      if (tests[i].corrupt != no_corrupt) begin
         pick_flip_mask(mask);
      end
      for (int k = 0; k < frame_words; k++) begin
         @(negedge gtx_tx_clk);
         link_dead = tests[i].dead;
         flip_mask = (k == tests[i].corrupt) ? mask : 16'h0000;
         if (k == 0) begin
            wire_name          = tests[i].name;
            wire_payload.data0 = tests[i].data0;
            wire_payload.data1 = tests[i].data1;
            wire_loc           = tests[i].location;
            if (i + 1 < n_tests) begin
               // Next frame's payload, picked up at its start
               tx_valid         = 1'b1;
               tx_payload.data0 = tests[i + 1].data0;
               tx_payload.data1 = tests[i + 1].data1;
               location         = tests[i + 1].location;
            end else begin
               transmit_en = 1'b0;
            end
         end else begin
            tx_valid = 1'b0;
         end
      end
   endtask

   // --------------------
   // Main sequence
   // --------------------
   initial begin
      rst          = 1'b1;
      transmit_en  = 1'b0;
      tx_valid     = 1'b0;
      location     = tests[0].location;
      tx_payload   = '0;
      link_dead    = 1'b0;
      flip_mask    = 16'h0000;
      wire_name    = "startup";
      wire_payload = '0;
      wire_loc     = '0;
      lfsr_state   = 32'h90ac_a7a2;
      repeat (3) @(posedge gtx_tx_clk);
      @(negedge gtx_tx_clk);
      rst = 1'b0;
      // Link idles on commas before the first frame
      repeat (4) @(negedge gtx_tx_clk);
      tx_valid         = 1'b1;
      tx_payload.data0 = tests[0].data0;
      tx_payload.data1 = tests[0].data1;
      @(negedge gtx_tx_clk);
      tx_valid    = 1'b0;
      transmit_en = 1'b1;
      for (int i = 0; i < n_tests; i++) begin
         do begin
            @(posedge gtx_tx_clk);
         end while (!UUT.tx_send);
         drive_frame(i);
      end
      @(negedge gtx_tx_clk);
      link_dead = 1'b0;
      flip_mask = 16'h0000;
      wire_name = "idle";
      repeat (3 * frame_words) @(negedge gtx_tx_clk);
      $display("checked %0d tests, %0d errors", n_tests, checker_errors);
      if (checker_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

   // Watchdog
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < timeout_cycles) begin
         @(posedge gtx_tx_clk);
         cycle_cnt++;
      end
      $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
      $display("checked %0d tests, %0d errors, 1 timeout", n_tests, checker_errors);
      $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/chitchat_crc16.sv */
// CRC-16 register with per-frame clear and one-word-per-cycle update
`default_nettype none

module chitchat_crc16 (
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  logic        update,
   input  logic [15:0] word,
   output logic [15:0] crc
);
   import chitchat_pkg::*;

   // All 16 bits of a word in one step, MSB first
   function automatic logic [15:0] crc_step(input logic [15:0] c, input logic [15:0] d);
      logic [15:0] r;
      logic        fb;
      r = c;
      for (int i = 15; i >= 0; i--) begin
         fb = r[15] ^ d[i];
         r  = {r[14:0], 1'b0};
         if (fb) begin
            r = r ^ crc_poly;
         end
      end
      return r;
   endfunction

   always_ff @(posedge clk) begin
      if (rst) begin
         crc <= crc_init;
      end else if (clear) begin
         crc <= crc_init;
      end else if (update) begin
         crc <= crc_step(crc, word);
      end
   end

endmodule

`default_nettype wire

/* hdl/chitchat_pkg.sv */
// Frame layout, word indices, comma and CRC constants, fault codes and frame word types
`default_nettype none

package chitchat_pkg;

   // --------------------
   // Frame layout
   // --------------------
   localparam logic [3:0] protocol_ver = 4'd1;
   localparam int         frame_words  = 11;

   localparam logic [3:0] w_comma     = 4'd0;
   localparam logic [3:0] w_header    = 4'd1;
   localparam logic [3:0] w_rev_hi    = 4'd2;
   localparam logic [3:0] w_rev_lo    = 4'd3;
   localparam logic [3:0] w_d0_hi     = 4'd4;
   localparam logic [3:0] w_d0_lo     = 4'd5;
   localparam logic [3:0] w_d1_hi     = 4'd6;
   localparam logic [3:0] w_d1_lo     = 4'd7;
   localparam logic [3:0] w_frame_cnt = 4'd8;
   localparam logic [3:0] w_lback_cnt = 4'd9;
   localparam logic [3:0] w_crc       = 4'd10;

   // K28.5 in the low byte, sent with k high
   localparam logic [15:0] comma_code = 16'h3cbc;

   // CCITT polynomial, all-ones seed
   localparam logic [15:0] crc_init = 16'hffff;
   localparam logic [15:0] crc_poly = 16'h1021;

   // Four frames without a comma
   localparam int los_limit = 4 * frame_words;

   // --------------------
   // Faults
   // --------------------
   typedef struct packed {
      logic cnt_err;   // frame counter did not continue
      logic k_err;     // k flag inside a frame
      logic crc_err;
   } fault_t;

   localparam fault_t fault_none = '{cnt_err: 1'b0, k_err: 1'b0, crc_err: 1'b0};
   localparam fault_t fault_k    = '{cnt_err: 1'b0, k_err: 1'b1, crc_err: 1'b0};

   // --------------------
   // Frame words
   // --------------------
   typedef struct packed {
      logic [3:0] protocol_ver;
      logic [2:0] gateware_type;
      logic [2:0] location;
      logic [5:0] reserved;
   } header_t;

   // Word 1 is raw data on the wire and a header to both ends
   typedef union packed {
      logic [15:0] raw;
      header_t     header;
   } frame_word_u;

   typedef struct packed {
      logic [31:0] data1;
      logic [31:0] data0;
   } payload_t;

   typedef struct packed {
      logic [3:0]  protocol_ver;
      logic [2:0]  gateware_type;
      logic [2:0]  location;
      logic [31:0] rev_id;
   } rx_info_t;

endpackage

`default_nettype wire

/* hdl/chitchat_rx.sv */
// Receive deframer with comma alignment, CRC and counter check, fault report and LOS timer
`default_nettype none

module chitchat_rx (
   input  logic                   gtx_tx_clk,
   input  logic                   rst,
   input  logic [15:0]            gtx_d,
   input  logic                   gtx_k,
   output logic                   rx_valid,
   output logic                   frame_drop,
   output chitchat_pkg::fault_t   fault,
   output chitchat_pkg::payload_t payload,
   output chitchat_pkg::rx_info_t info,
   output logic [15:0]            frame_cnt,
   output logic [15:0]            lback_cnt,
   output logic                   los
);
   import chitchat_pkg::*;

   typedef enum logic [1:0] {
      st_hunt,
      st_collect,
      st_check
   } state_t;

   state_t      state;
   logic [3:0]  idx;
   logic        comma;
   frame_word_u hdr_q;
   logic [31:0] rev_q;
   payload_t    pay_q;
   logic [15:0] cnt_q;
   logic [15:0] lb_q;
   logic [15:0] exp_cnt;
   logic        cnt_valid;
   logic [15:0] crc;
   logic        crc_update;
   fault_t      chk_fault;
   logic        frame_ok;
   logic [$clog2(los_limit + 1) - 1:0] los_timer;

   assign comma      = gtx_k && (gtx_d == comma_code);
   assign crc_update = (state == st_collect) && !gtx_k;

   // Fault vector as seen on the CRC word
   always_comb begin
      chk_fault.crc_err = (crc != gtx_d);
      chk_fault.k_err   = gtx_k;
      chk_fault.cnt_err = cnt_valid && (cnt_q != exp_cnt);
   end

   assign frame_ok = (state == st_check) && (chk_fault == fault_none);

   // Every comma restarts the CRC, so realignment is free
   chitchat_crc16 i_crc (
      .clk    (gtx_tx_clk),
      .rst    (rst),
      .clear  (comma),
      .update (crc_update),
      .word   (gtx_d),
      .crc    (crc)
   );

   // --------------------
   // Alignment FSM
   // --------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         state      <= st_hunt;
         idx        <= w_comma;
         rx_valid   <= 1'b0;
         frame_drop <= 1'b0;
         fault      <= fault_none;
         exp_cnt    <= '0;
         cnt_valid  <= 1'b0;
         frame_cnt  <= '0;
         lback_cnt  <= '0;
      end else begin
         rx_valid   <= 1'b0;
         frame_drop <= 1'b0;
         case (state)
            st_hunt: begin
               if (comma) begin
                  state <= st_collect;
                  idx   <= w_header;
               end
            end
            st_collect: begin
               if (gtx_k) begin
                  // Close the frame now and realign if this was a comma
                  frame_drop <= 1'b1;
                  fault      <= fault_k;
                  exp_cnt    <= exp_cnt + 16'd1;
                  state      <= comma ? st_collect : st_hunt;
                  idx        <= w_header;
               end else begin
                  if (idx == w_lback_cnt) begin
                     state <= st_check;
                  end
                  idx <= idx + 4'd1;
               end
            end
            default: begin
               if (frame_ok) begin
                  rx_valid  <= 1'b1;
                  frame_cnt <= cnt_q;
                  lback_cnt <= lb_q;
                  exp_cnt   <= cnt_q + 16'd1;
                  cnt_valid <= 1'b1;
               end else begin
                  // Dropped frames still move the expected count on
                  frame_drop <= 1'b1;
                  fault      <= chk_fault;
                  exp_cnt    <= exp_cnt + 16'd1;
               end
               state <= comma ? st_collect : st_hunt;
               idx   <= w_header;
            end
         endcase
         // No counter history across a lost link
         if (los) begin
            cnt_valid <= 1'b0;
         end
      end
   end

   // --------------------
   // Field capture
   // --------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (crc_update) begin
         case (idx)
            w_header:    hdr_q.raw          <= gtx_d;
            w_rev_hi:    rev_q[31:16]       <= gtx_d;
            w_rev_lo:    rev_q[15:0]        <= gtx_d;
            w_d0_hi:     pay_q.data0[31:16] <= gtx_d;
            w_d0_lo:     pay_q.data0[15:0]  <= gtx_d;
            w_d1_hi:     pay_q.data1[31:16] <= gtx_d;
            w_d1_lo:     pay_q.data1[15:0]  <= gtx_d;
            w_frame_cnt: cnt_q              <= gtx_d;
            w_lback_cnt: lb_q               <= gtx_d;
            default: ;
         endcase
      end
      if (frame_ok) begin
         payload            <= pay_q;
         info.protocol_ver  <= hdr_q.header.protocol_ver;
         info.gateware_type <= hdr_q.header.gateware_type;
         info.location      <= hdr_q.header.location;
         info.rev_id        <= rev_q;
      end
   end

   // --------------------
   // Loss of signal
   // --------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         los_timer <= '0;
         los       <= 1'b0;
      end else if (comma) begin
         los_timer <= '0;
         los       <= 1'b0;
      end else if (los_timer != los_limit) begin
         los_timer <= los_timer + 1'b1;
         if (los_timer == los_limit - 1) begin
            los <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/chitchat_tx.sv */
// Transmit framer with word sequencer, header build, CRC insertion and frame counter
`default_nettype none

module chitchat_tx #(
   parameter logic [31:0] rev_id        = 32'h0,
   parameter logic [2:0]  gateware_type = 3'd0
) (
   input  logic                  gtx_tx_clk,
   input  logic                  rst,
   input  logic                  transmit_en,
   input  logic [2:0]            location,
   input  chitchat_pkg::payload_t payload,
   input  logic [15:0]           lback_cnt,
   output logic                  tx_send,
   output logic [15:0]           local_frame_cnt,
   output logic [15:0]           gtx_d,
   output logic                  gtx_k
);
   import chitchat_pkg::*;

   logic        active;
   logic [3:0]  idx;
   payload_t    pay_q;
   logic [2:0]  loc_q;
   frame_word_u hdr;
   logic [15:0] word;
   logic [15:0] crc;
   logic        crc_update;

   // Start a new frame whenever the link is enabled and no frame runs
   assign tx_send = transmit_en && !active;

   // Words 1 to 9 go into the CRC
   assign crc_update = active && (idx != w_crc);

   always_comb begin
      hdr.header.protocol_ver  = protocol_ver;
      hdr.header.gateware_type = gateware_type;
      hdr.header.location      = loc_q;
      hdr.header.reserved      = '0;
   end

   // --------------------
   // Word select
   // --------------------
   always_comb begin
      word = comma_code;
      if (active) begin
         case (idx)
            w_header:    word = hdr.raw;
            w_rev_hi:    word = rev_id[31:16];
            w_rev_lo:    word = rev_id[15:0];
            w_d0_hi:     word = pay_q.data0[31:16];
            w_d0_lo:     word = pay_q.data0[15:0];
            w_d1_hi:     word = pay_q.data1[31:16];
            w_d1_lo:     word = pay_q.data1[15:0];
            w_frame_cnt: word = local_frame_cnt;
            w_lback_cnt: word = lback_cnt;
            w_crc:       word = crc;
            default:     word = comma_code;
         endcase
      end
   end

   chitchat_crc16 i_crc (
      .clk    (gtx_tx_clk),
      .rst    (rst),
      .clear  (tx_send),
      .update (crc_update),
      .word   (word),
      .crc    (crc)
   );

   // --------------------
   // Sequencer
   // --------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         active          <= 1'b0;
         idx             <= w_comma;
         local_frame_cnt <= '0;
         gtx_d           <= comma_code;
         gtx_k           <= 1'b1;
      end else begin
         gtx_d <= word;
         gtx_k <= !active;
         if (tx_send) begin
            // Comma goes out now, header next
            active          <= 1'b1;
            idx             <= w_header;
            local_frame_cnt <= local_frame_cnt + 16'd1;
         end else if (active) begin
            if (idx == w_crc) begin
               active <= 1'b0;
            end else begin
               idx <= idx + 4'd1;
            end
         end
      end
   end

   // Payload and location fixed for the whole frame
   always_ff @(posedge gtx_tx_clk) begin
      if (tx_send) begin
         pay_q <= payload;
         loc_q <= location;
      end
   end

endmodule

`default_nettype wire

/* hdl/chitchat_txrx_wrap.sv */
// Link top level with payload latch, loopback count, fault counter, latency and tx/rx instances
`default_nettype none

module chitchat_txrx_wrap #(
   parameter logic [31:0] rev_id        = 32'h0,
   parameter logic [2:0]  gateware_type = 3'd0
) (
   input  logic                   gtx_tx_clk,
   input  logic                   rst,
   input  logic                   transmit_en,
   input  logic                   tx_valid,
   input  logic [2:0]             location,
   input  chitchat_pkg::payload_t tx_payload,
   output logic                   rx_valid,
   output chitchat_pkg::payload_t rx_payload,
   output chitchat_pkg::rx_info_t rx_info,
   output logic [15:0]            rx_frame_cnt,
   output logic                   ccrx_frame_drop,
   output chitchat_pkg::fault_t   ccrx_fault,
   output logic [15:0]            ccrx_fault_cnt,
   output logic                   ccrx_los,
   output logic [15:0]            txrx_latency,
   output logic [15:0]            gtx_tx_d,
   output logic                   gtx_tx_k,
   input  logic [15:0]            gtx_rx_d,
   input  logic                   gtx_rx_k
);
   import chitchat_pkg::*;

   payload_t    tx_pay_q;
   logic        tx_send;          // frame start, also watched by the testbench
   logic [15:0] local_frame_cnt;
   logic [15:0] last_good_cnt;
   logic [15:0] rx_lback_cnt;

   // Latest payload wins if the framer has not picked it up yet
   always_ff @(posedge gtx_tx_clk) begin
      if (tx_valid) begin
         tx_pay_q <= tx_payload;
      end
   end

   chitchat_tx #(
      .rev_id        (rev_id),
      .gateware_type (gateware_type)
   ) i_tx (
      .gtx_tx_clk      (gtx_tx_clk),
      .rst             (rst),
      .transmit_en     (transmit_en),
      .location        (location),
      .payload         (tx_pay_q),
      .lback_cnt       (last_good_cnt),
      .tx_send         (tx_send),
      .local_frame_cnt (local_frame_cnt),
      .gtx_d           (gtx_tx_d),
      .gtx_k           (gtx_tx_k)
   );

   chitchat_rx i_rx (
      .gtx_tx_clk (gtx_tx_clk),
      .rst        (rst),
      .gtx_d      (gtx_rx_d),
      .gtx_k      (gtx_rx_k),
      .rx_valid   (rx_valid),
      .frame_drop (ccrx_frame_drop),
      .fault      (ccrx_fault),
      .payload    (rx_payload),
      .info       (rx_info),
      .frame_cnt  (rx_frame_cnt),
      .lback_cnt  (rx_lback_cnt),
      .los        (ccrx_los)
   );

   // --------------------
   // Loopback and status
   // --------------------
   always_ff @(posedge gtx_tx_clk) begin
      if (rst) begin
         last_good_cnt  <= '0;
         txrx_latency   <= '0;
         ccrx_fault_cnt <= '0;
      end else begin
         if (rx_valid) begin
            last_good_cnt <= rx_frame_cnt;
            // Frames in flight between our send and the far end echo
            txrx_latency  <= local_frame_cnt - rx_lback_cnt;
         end
         if (ccrx_frame_drop && (ccrx_fault_cnt != 16'hffff)) begin
            ccrx_fault_cnt <= ccrx_fault_cnt + 16'd1;
         end
      end
   end

endmodule

`default_nettype wire

/* project.f */
hdl/chitchat_pkg.sv
hdl/chitchat_crc16.sv
hdl/chitchat_tx.sv
hdl/chitchat_rx.sv
hdl/chitchat_txrx_wrap.sv
dv/chitchat_checker.sv
dv/chitchat_tb.sv
